// File: Makefile
VERILATOR  := verilator
SIM_FLAGS  := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
TOP        := fpu_tb
FILELIST   := src.f
BUILD      := build
LOG        := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := verilog/fpu_config.svh

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

# a run that stops before its summary counts as a failure too
sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "sim: FAILED"; exit 1; fi
	@grep -q "All checks passed" $(LOG) || { echo "sim: no summary in $(LOG)"; exit 1; }
	@echo "sim: passed"

clean:
	rm -rf $(BUILD) $(LOG)

// File: sim/clock_gen.sv
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset low over the first three rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/fpu_checker.sv
`default_nettype none

module fpu_checker (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        order,
    input  wire        accepted,
    input  wire        done,
    input  wire [31:0] rd,
    input  wire        expect_valid,
    input  wire [31:0] expect_rd,
    input  wire        finish,
    output logic       busy,
    output int         errors,
    output int         checks
);

    // slowest block is fadd, done two cycles after acceptance
    localparam int max_latency = 2;

    logic        pending;
    logic [31:0] pending_rd;
    logic [31:0] held_rd;
    int          wait_cycles;

    assign busy = pending;

    task automatic compare_rd(input logic [31:0] want);
        checks = checks + 1;
        if (rd !== want) begin
            $display("Fail at %0t: rd expected %h, got %h", $time, want, rd);
            errors = errors + 1;
        end
    endtask

    task automatic report(input string what);
        $display("Error at %0t: %s", $time, what);
        errors = errors + 1;
    endtask

    // sampled at the rising edge, before the edge's updates land
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending     = 1'b0;
            pending_rd  = '0;
            held_rd     = '0;
            wait_cycles = 0;
            errors      = 0;
            checks      = 0;
        end else begin
            if (accepted && !order) begin
                report("accepted is high while no order is raised");
            end
            // rd keeps the last result outside done cycles, 0 after reset
            if (!done && rd !== held_rd) begin
                $display("Fail at %0t: rd expected %h (held), got %h", $time, held_rd, rd);
                errors = errors + 1;
            end
            if (accepted) begin
                if (!expect_valid) begin
                    report("an order was accepted with no expected result");
                end
                if (pending) begin
                    report("a second order was accepted before the previous done");
                end
                pending_rd  = expect_rd;
                pending     = 1'b1;
                wait_cycles = 0;
            end else if (pending && !done) begin
                wait_cycles = wait_cycles + 1;
                if (wait_cycles == max_latency + 1) begin
                    report("done did not arrive within the expected latency");
                end
            end
            if (done) begin
                if (!pending) begin
                    report("done pulsed with no order in flight");
                end else begin
                    compare_rd(pending_rd);
                    held_rd = pending_rd;
                end
                pending = 1'b0;
            end
            if (finish && pending) begin
                report("the run ended with an order still in flight");
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/fpu_tb.sv
`default_nettype none

module fpu_tb;
    import fpu_pkg::*;

    // one line of the tests file
    typedef struct packed {
        fpu_req_t    req;
        logic [31:0] rd;
    } test_rec_t;

    localparam int max_tests = 64;
    localparam int rec_words = 5;

    logic        clk;
    logic        rst_n;
    logic        order;
    fpu_req_t    req;
    logic        accepted;
    logic        done;
    logic [31:0] rd;
    logic        expect_valid;
    logic [31:0] expect_rd;
    logic        finish;
    logic        busy;
    int          errors;
    int          checks;

    logic [31:0] test_words [0:max_tests*rec_words-1];
    test_rec_t   tests [0:max_tests-1];
    int          n_tests;
    int          cycles      = 0;
    int          cycle_limit = max_tests * 8 + 20;

    clock_gen clock0 (.clk(clk), .rst_n(rst_n));

    fpu dut0 (
        .clk(clk), .rst_n(rst_n), .order(order), .req(req),
        .accepted(accepted), .done(done), .rd(rd));

    fpu_checker check0 (
        .clk(clk), .rst_n(rst_n), .order(order), .accepted(accepted),
        .done(done), .rd(rd), .expect_valid(expect_valid), .expect_rd(expect_rd),
        .finish(finish), .busy(busy), .errors(errors), .checks(checks));

    task automatic load_tests();
        int base;
        // a low byte of ff ends the list, also where the file stops short
        for (int i = 0; i < max_tests * rec_words; i++) begin
            test_words[i] = (i << 8) | 32'hff;
        end
        $readmemh("sim/fpu_tests.txt", test_words);
        n_tests = 0;
        base    = 0;
        while (n_tests < max_tests && test_words[base][7:0] != 8'hff) begin
            tests[n_tests].req.func7 = test_words[base][6:0];
            tests[n_tests].req.func3 = test_words[base + 1][2:0];
            tests[n_tests].req.rs1   = test_words[base + 2];
            tests[n_tests].req.rs2   = test_words[base + 3];
            tests[n_tests].rd        = test_words[base + 4];
            n_tests = n_tests + 1;
            base    = base + rec_words;
        end
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_order(input test_rec_t t);
        order        = 1'b1;
        req          = t.req;
        expect_valid = 1'b1;
        expect_rd    = t.rd;
        @(posedge clk);
        while (!accepted) begin
            @(posedge clk);
        end
        @(negedge clk);
        order        = 1'b0;
        expect_valid = 1'b0;
    endtask

    initial begin
        int seed;
        int gap;
        order        = 1'b0;
        req          = '0;
        expect_valid = 1'b0;
        expect_rd    = '0;
        finish       = 1'b0;
        seed         = $urandom(32'hbf28);
        load_tests();
        cycle_limit = n_tests * 8 + 20;

        wait (rst_n === 1'b1);
        // a few idle cycles so the reset values get watched
        repeat (2) @(negedge clk);
        for (int i = 0; i < n_tests; i++) begin
            gap = $urandom % 4;
            repeat (gap) @(negedge clk);
            send_order(tests[i]);
        end
        while (busy) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);

        finish = 1'b1;
        @(negedge clk);
        finish = 1'b0;
        $display("%0d errors, %0d of %0d results checked", errors, checks, n_tests);
        if (n_tests == 0) begin
            $display("no tests were read from sim/fpu_tests.txt");
        end else if (checks != n_tests) begin
            $display("the number of results seen does not match the number of tests");
        end
        if (errors == 0 && n_tests > 0 && checks == n_tests) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // run limit scales with the number of tests
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the run did not complete", cycles);
            $display("Checks failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sim/fpu_tests.txt
// columns: func7 func3 rs1 rs2 expected_rd, all hex, one test per line
// a func7 word of ff marks the end of the list
00 0 3f800000 40000000 40400000
00 0 3f800000 c0200000 bfc00000
00 0 3fc00000 bfc00000 00000000
00 0 3f800000 33800000 3f800000
00 0 00000000 40a00000 40a00000
00 0 7f7fffff 7f7fffff 7f800000
04 0 40400000 3f800000 40000000
04 0 3f800000 40400000 c0000000
04 0 3f800000 33400000 3f7fffff
04 0 ff7fffff 7f7fffff ff800000
08 0 3fc00000 40000000 40400000
08 0 40400000 40400000 41100000
08 0 c0000000 40200000 c0a00000
08 0 3f800001 3f800001 3f800002
08 0 8d800000 0d800000 80000000
08 0 71800000 71800000 7f800000
68 0 00000005 00000000 40a00000
68 0 fffffff9 00000000 c0e00000
68 0 7fffffff 00000000 4effffff
68 0 80000000 00000000 cf000000
60 0 40b00000 00000000 00000005
60 0 c0300000 00000000 fffffffe
60 0 53800000 00000000 7fffffff
60 0 d3800000 00000000 80000000
70 0 12345678 00000000 12345678
78 0 c0de0001 ffffffff c0de0001
10 0 3fc00000 bf800000 bfc00000
10 1 3fc00000 bf800000 3fc00000
10 2 c0000000 bf800000 40000000
50 2 00000000 80000000 00000001
50 1 80000000 00000000 00000000
50 0 80000000 00000000 00000001
50 1 c0000000 3f800000 00000001
50 1 bf800000 c0000000 00000000
7f 0 3f800000 40000000 00000000
ff 0 00000000 00000000 00000000

// File: src.f
+incdir+verilog
verilog/fpu_pkg.sv
verilog/fadd.sv
verilog/fmul.sv
verilog/fconv.sv
verilog/fsign_compare.sv
verilog/fpu.sv
sim/clock_gen.sv
sim/fpu_checker.sv
sim/fpu_tb.sv

// File: verilog/fadd.sv
`default_nettype none

module fadd (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         start,
    input  wire  [31:0] a,
    input  wire  [31:0] b,
    output logic        done,
    output logic [31:0] result
);
    import fpu_pkg::*;

    // aligned operands between the two stages
    typedef struct packed {
        logic        sign;
        logic        sub;
        logic [7:0]  exp;
        logic [26:0] mag_hi;
        logic [26:0] mag_lo;
    } align_t;

    fp_word_u    ua;
    fp_word_u    ub;
    fp_word_u    op_hi;
    fp_word_u    op_lo;
    logic        swap;
    logic [23:0] sig_hi;
    logic [23:0] sig_lo;
    logic [7:0]  exp_diff;
    logic [53:0] shifted;
    logic [26:0] lo_aligned;
    align_t      s1_next;
    align_t      s1;
    logic        s1_valid;

    logic [27:0] sum;
    logic [27:0] norm;
    logic [4:0]  lz;
    logic [9:0]  exp_norm;
    fp_word_u    res_next;

    // leading zeros of the 28-bit sum, 28 when it is zero
    function automatic logic [4:0] lzc28(input logic [27:0] v);
        logic [4:0] n;
        n = 5'd28;
        for (int i = 0; i < 28; i++) begin
            if (v[i]) begin
                n = 5'(27 - i);
            end
        end
        return n;
    endfunction

    // stage 1: order by magnitude, align the smaller operand
    always_comb begin
        ua.raw = a;
        ub.raw = b;
        swap   = ub.raw[30:0] > ua.raw[30:0];
        op_hi  = swap ? ub : ua;
        op_lo  = swap ? ua : ub;
        // subnormals flush to zero
        sig_hi   = (op_hi.f.exp != 8'd0) ? {1'b1, op_hi.f.frac} : 24'd0;
        sig_lo   = (op_lo.f.exp != 8'd0) ? {1'b1, op_lo.f.frac} : 24'd0;
        exp_diff = op_hi.f.exp - op_lo.f.exp;
        shifted  = {sig_lo, 30'd0} >> exp_diff;
        // guard, round and sticky below the significand
        if (exp_diff >= 8'd27) begin
            lo_aligned = {26'd0, |sig_lo};
        end else begin
            lo_aligned = {shifted[53:28], shifted[27] | (|shifted[26:0])};
        end
        s1_next.sign   = op_hi.f.sign;
        s1_next.sub    = op_hi.f.sign ^ op_lo.f.sign;
        s1_next.exp    = op_hi.f.exp;
        s1_next.mag_hi = {sig_hi, 3'd0};
        s1_next.mag_lo = lo_aligned;
    end

    // stage 2: add, normalize, truncate
    always_comb begin
        if (s1.sub) begin
            sum = {1'b0, s1.mag_hi} - {1'b0, s1.mag_lo};
        end else begin
            sum = {1'b0, s1.mag_hi} + {1'b0, s1.mag_lo};
        end
        lz       = lzc28(sum);
        norm     = sum << lz;
        exp_norm = {2'b0, s1.exp} + 10'd1 - {5'd0, lz};

        res_next.f.sign = s1.sign;
        res_next.f.exp  = exp_norm[7:0];
        res_next.f.frac = norm[26:4];
        if (sum == 28'd0) begin
            // exact cancellation gives +0
            res_next.raw = {s1.sign & ~s1.sub, 31'd0};
        end else if (exp_norm[9] || exp_norm == 10'd0) begin
            res_next.raw = {s1.sign, 31'd0};
        end else if (exp_norm >= 10'd255) begin
            res_next.raw = {s1.sign, 8'hff, 23'd0};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            s1_valid <= start;
            done     <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            s1 <= s1_next;
        end
        if (s1_valid) begin
            result <= res_next.raw;
        end
    end

    // the top level must hold new orders while this unit is busy
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !s1_valid && !done)
        else $error("fadd: start while an operation is in flight");

endmodule

`default_nettype wire

// File: verilog/fconv.sv
`default_nettype none

module fconv (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         start,
    input  wire         to_int,
    input  wire  [31:0] a,
    output logic        done,
    output logic [31:0] result
);
    import fpu_pkg::*;

    fp_word_u    ua;
    fp_word_u    itof_w;
    logic        neg;
    logic [31:0] mag;
    logic [5:0]  lz;
    logic [31:0] norm;
    logic [7:0]  exp_off;
    logic [54:0] wide;
    logic [31:0] int_mag;
    logic [31:0] ftoi_w;

    // leading zeros of a 32-bit value, 32 when it is zero
    function automatic logic [5:0] lzc32(input logic [31:0] v);
        logic [5:0] n;
        n = 6'd32;
        for (int i = 0; i < 32; i++) begin
            if (v[i]) begin
                n = 6'(31 - i);
            end
        end
        return n;
    endfunction

    // int to float
    always_comb begin
        neg  = a[31];
        mag  = neg ? (~a + 32'd1) : a;
        lz   = lzc32(mag);
        norm = mag << lz;
        itof_w.f.sign = neg;
        itof_w.f.exp  = 8'd158 - {2'd0, lz};
        itof_w.f.frac = norm[30:8];
        if (mag == 32'd0) begin
            itof_w.raw = 32'd0;
        end
    end

    // float to int, toward zero with saturation
    always_comb begin
        ua.raw  = a;
        exp_off = ua.f.exp - 8'd127;
        wide    = {31'd0, 1'b1, ua.f.frac} << exp_off[4:0];
        int_mag = wide[54:23];
        if (ua.f.exp < 8'd127) begin
            ftoi_w = 32'd0;
        end else if (ua.f.exp >= 8'd158) begin
            ftoi_w = ua.f.sign ? 32'h8000_0000 : 32'h7fff_ffff;
        end else begin
            ftoi_w = ua.f.sign ? (~int_mag + 32'd1) : int_mag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            result <= to_int ? ftoi_w : itof_w.raw;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fmul.sv
`default_nettype none

module fmul (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         start,
    input  wire  [31:0] a,
    input  wire  [31:0] b,
    output logic        done,
    output logic [31:0] result
);
    import fpu_pkg::*;

    fp_word_u    ua;
    fp_word_u    ub;
    fp_word_u    res_next;
    logic        sign;
    logic [47:0] product;
    logic [9:0]  exp_sum;

    always_comb begin
        ua.raw  = a;
        ub.raw  = b;
        sign    = ua.f.sign ^ ub.f.sign;
        product = {24'd0, 1'b1, ua.f.frac} * {24'd0, 1'b1, ub.f.frac};
        // product in [1,4), one bit of normalization at most
        exp_sum = {2'b0, ua.f.exp} + {2'b0, ub.f.exp} - 10'd127 + {9'd0, product[47]};

        res_next.f.sign = sign;
        res_next.f.exp  = exp_sum[7:0];
        if (product[47]) begin
            res_next.f.frac = product[46:24];
        end else begin
            res_next.f.frac = product[45:23];
        end

        if (ua.f.exp == 8'd0 || ub.f.exp == 8'd0) begin
            res_next.raw = {sign, 31'd0};
        end else if (exp_sum[9] || exp_sum == 10'd0) begin
            // underflow flushes
            res_next.raw = {sign, 31'd0};
        end else if (exp_sum >= 10'd255) begin
            res_next.raw = {sign, 8'hff, 23'd0};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            result <= res_next.raw;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fpu.sv
`default_nettype none

`include "fpu_config.svh"

module fpu (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  order,
    input  wire fpu_pkg::fpu_req_t req,
    output logic                 accepted,
    output logic                 done,
    output logic [`FPU_WORD-1:0] rd
);

    logic                 doing;
    logic                 order_able;

    logic                 sel_fadd;
    logic                 sel_fsub;
    logic                 sel_fmul;
    logic                 sel_conv;
    logic                 sel_sc;
    logic                 sel_mv;
    logic                 sel_err;

    logic                 fadd_done;
    logic                 fsub_done;
    logic                 fmul_done;
    logic                 conv_done;
    logic                 sc_done;
    logic                 mv_done;
    logic                 err_done;
    logic [`FPU_WORD-1:0] fadd_rd;
    logic [`FPU_WORD-1:0] fsub_rd;
    logic [`FPU_WORD-1:0] fmul_rd;
    logic [`FPU_WORD-1:0] conv_rd;
    logic [`FPU_WORD-1:0] sc_rd;
    logic [`FPU_WORD-1:0] fsub_rs2;

    logic [`FPU_WORD-1:0] rd_buf;
    logic [`FPU_WORD-1:0] next_rd;

    // idle and asked, so take the order this cycle
    assign order_able = order & ~doing;
    assign accepted   = order_able;

    always_comb begin
        sel_fadd = 1'b0;
        sel_fsub = 1'b0;
        sel_fmul = 1'b0;
        sel_conv = 1'b0;
        sel_sc   = 1'b0;
        sel_mv   = 1'b0;
        sel_err  = 1'b0;
        case (req.func7)
            `FUNC7_FADD:                sel_fadd = 1'b1;
            `FUNC7_FSUB:                sel_fsub = 1'b1;
            `FUNC7_FMUL:                sel_fmul = 1'b1;
            `FUNC7_FTOI, `FUNC7_ITOF:   sel_conv = 1'b1;
            `FUNC7_FSGNJ, `FUNC7_FCOMP: sel_sc   = 1'b1;
            `FUNC7_FMVI, `FUNC7_IMVF:   sel_mv   = 1'b1;
            default:                    sel_err  = 1'b1;
        endcase
    end

    // subtract is add with rs2 negated
    assign fsub_rs2 = {~req.rs2[31], req.rs2[30:0]};

    fadd m_fadd (
        .clk(clk), .rst_n(rst_n), .start(order_able & sel_fadd),
        .a(req.rs1), .b(req.rs2), .done(fadd_done), .result(fadd_rd));

    fadd m_fsub (
        .clk(clk), .rst_n(rst_n), .start(order_able & sel_fsub),
        .a(req.rs1), .b(fsub_rs2), .done(fsub_done), .result(fsub_rd));

    fmul m_fmul (
        .clk(clk), .rst_n(rst_n), .start(order_able & sel_fmul),
        .a(req.rs1), .b(req.rs2), .done(fmul_done), .result(fmul_rd));

    fconv m_fconv (
        .clk(clk), .rst_n(rst_n), .start(order_able & sel_conv),
        .to_int(req.func7 == `FUNC7_FTOI), .a(req.rs1),
        .done(conv_done), .result(conv_rd));

    fsign_compare m_fsc (
        .start(order_able & sel_sc), .compare(req.func7 == `FUNC7_FCOMP),
        .func3(req.func3), .a(req.rs1), .b(req.rs2),
        .done(sc_done), .result(sc_rd));

    // raw moves and unknown codes finish here, same cycle
    assign mv_done  = order_able & sel_mv;
    assign err_done = order_able & sel_err;

    assign done = fadd_done | fsub_done | fmul_done | conv_done |
                  sc_done | mv_done | err_done;

    always_comb begin
        if (fadd_done) begin
            next_rd = fadd_rd;
        end else if (fsub_done) begin
            next_rd = fsub_rd;
        end else if (fmul_done) begin
            next_rd = fmul_rd;
        end else if (conv_done) begin
            next_rd = conv_rd;
        end else if (sc_done) begin
            next_rd = sc_rd;
        end else if (mv_done) begin
            next_rd = req.rs1;
        end else if (err_done) begin
            next_rd = '0;
        end else begin
            next_rd = rd_buf;
        end
    end

    // rd shows the new result in the done cycle, then the held copy
    assign rd = next_rd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            doing  <= 1'b0;
            rd_buf <= '0;
        end else begin
            doing <= ~done & (doing | order_able);
            if (done) begin
                rd_buf <= next_rd;
            end
        end
    end

    a_one_done: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({fadd_done, fsub_done, fmul_done, conv_done, sc_done, mv_done, err_done}))
        else $error("fpu: more than one block done");

    // a block only finishes work that was handed to it
    a_done_owned: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> doing || accepted)
        else $error("fpu: done without an order in flight");

endmodule

`default_nettype wire

// File: verilog/fpu_config.svh
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// word and field widths
`define FPU_WORD      32
`define FPU_FUNC7_LEN 7
`define FPU_FUNC3_LEN 3

// func7 opcodes, risc-v F extension layout
`define FUNC7_FADD  7'b0000000
`define FUNC7_FSUB  7'b0000100
`define FUNC7_FMUL  7'b0001000
`define FUNC7_FSGNJ 7'b0010000
`define FUNC7_FCOMP 7'b1010000
`define FUNC7_FTOI  7'b1100000
`define FUNC7_ITOF  7'b1101000
`define FUNC7_FMVI  7'b1110000
`define FUNC7_IMVF  7'b1111000

// func3 sub-operations (sign injection and compare overlap)
`define FUNC3_SGNJ  3'b000
`define FUNC3_SGNJN 3'b001
`define FUNC3_SGNJX 3'b010
`define FUNC3_FEQ   3'b010
`define FUNC3_FLT   3'b001
`define FUNC3_FLE   3'b000

`endif

// File: verilog/fpu_pkg.sv
`default_nettype none

`include "fpu_config.svh"

package fpu_pkg;

    // single precision layout
    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] frac;
    } fp_fields_t;

    // one word, seen as float fields or as a plain integer
    typedef union packed {
        fp_fields_t                f;
        logic [`FPU_WORD-1:0]      raw;
    } fp_word_u;

    // one order from the core
    typedef struct packed {
        logic [`FPU_FUNC7_LEN-1:0] func7;
        logic [`FPU_FUNC3_LEN-1:0] func3;
        logic [`FPU_WORD-1:0]      rs1;
        logic [`FPU_WORD-1:0]      rs2;
    } fpu_req_t;

endpackage

`default_nettype wire

// File: verilog/fsign_compare.sv
`default_nettype none

`include "fpu_config.svh"

module fsign_compare (
    input  wire                      start,
    input  wire                      compare,
    input  wire [`FPU_FUNC3_LEN-1:0] func3,
    input  wire [`FPU_WORD-1:0]      a,
    input  wire [`FPU_WORD-1:0]      b,
    output logic                     done,
    output logic [`FPU_WORD-1:0]     result
);
    import fpu_pkg::*;

    fp_word_u ua;
    fp_word_u ub;
    fp_word_u res_w;
    logic     both_zero;
    logic     eq;
    logic     lt;

    assign done = start;

    always_comb begin
        ua.raw = a;
        ub.raw = b;
        // +0 and -0 compare equal
        both_zero = (ua.raw[30:0] == 31'd0) && (ub.raw[30:0] == 31'd0);
        eq        = both_zero || (ua.raw == ub.raw);
        if (both_zero) begin
            lt = 1'b0;
        end else if (ua.f.sign != ub.f.sign) begin
            lt = ua.f.sign;
        end else if (!ua.f.sign) begin
            lt = ua.raw[30:0] < ub.raw[30:0];
        end else begin
            // both negative, larger magnitude is smaller
            lt = ua.raw[30:0] > ub.raw[30:0];
        end

        res_w = ua;
        if (compare) begin
            case (func3)
                `FUNC3_FEQ: res_w.raw = {31'd0, eq};
                `FUNC3_FLT: res_w.raw = {31'd0, lt};
                `FUNC3_FLE: res_w.raw = {31'd0, lt | eq};
                default:    res_w.raw = 32'd0;
            endcase
        end else begin
            case (func3)
                `FUNC3_SGNJ:  res_w.f.sign = ub.f.sign;
                `FUNC3_SGNJN: res_w.f.sign = ~ub.f.sign;
                `FUNC3_SGNJX: res_w.f.sign = ua.f.sign ^ ub.f.sign;
                default:      res_w.f.sign = ua.f.sign;
            endcase
        end
        result = res_w.raw;
    end

endmodule

`default_nettype wire
